//--- llc_slice.f
logic/llc_pkg.sv
logic/llc_tag_store.sv
logic/llc_set_buffer.sv
logic/llc_input_select.sv
logic/llc_process_request.sv
logic/llc_slice.sv
tb/llc_slice_checker.sv
tb/llc_slice_tb.sv

//--- logic/llc_input_select.sv
`timescale 1ns/1ps

module llc_input_select (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rsp_valid,
    input  llc_pkg::coh_msg_t    rsp_msg,
    input  llc_pkg::line_addr_t  rsp_addr,
    input  llc_pkg::line_t       rsp_line,
    input  logic                 rd_valid,
    input  llc_pkg::line_addr_t  rd_addr,
    input  logic                 flush_valid,
    input  llc_pkg::llc_set_t    flush_set,
    input  logic                 recall_valid,
    input  llc_pkg::line_addr_t  recall_arm_addr,
    input  logic                 op_taken,
    input  logic                 clr_recall,
    output llc_pkg::proc_op_t    op,
    output llc_pkg::line_addr_t  op_addr,
    output llc_pkg::coh_msg_t    op_msg,
    output llc_pkg::line_t       op_line,
    output logic                 recall_pending,
    output llc_pkg::line_addr_t  recall_addr
);

    logic                rsp_pend, flush_pend, rd_pend;
    llc_pkg::line_addr_t rsp_addr_q, rd_addr_q;
    llc_pkg::llc_set_t   flush_set_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_pend <= 1'b0;
            flush_pend <= 1'b0;
            rd_pend <= 1'b0;
            recall_pending <= 1'b0;
        end else begin
            if (op_taken && op == llc_pkg::OP_RSP) rsp_pend <= 1'b0;
            if (op_taken && op == llc_pkg::OP_FLUSH) flush_pend <= 1'b0;
            if (op_taken && op == llc_pkg::OP_READ) rd_pend <= 1'b0;
            if (clr_recall) recall_pending <= 1'b0;
            // a new strobe wins over a clear in the same cycle.
            if (rsp_valid) rsp_pend <= 1'b1;
            if (flush_valid) flush_pend <= 1'b1;
            if (rd_valid) rd_pend <= 1'b1;
            if (recall_valid) recall_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            op_msg <= rsp_msg;
            rsp_addr_q <= rsp_addr;
            op_line <= rsp_line;
        end
        if (flush_valid) flush_set_q <= flush_set;
        if (rd_valid) rd_addr_q <= rd_addr;
        if (recall_valid) recall_addr <= recall_arm_addr;
    end

    always_comb begin
        op = llc_pkg::OP_NONE;
        op_addr = rd_addr_q;
        if (rsp_pend) begin
            op = llc_pkg::OP_RSP;
            op_addr = rsp_addr_q;
        end else if (flush_pend) begin
            op = llc_pkg::OP_FLUSH;
            op_addr = {{llc_pkg::TAG_BITS{1'b0}}, flush_set_q};
        end else if (rd_pend) begin
            op = llc_pkg::OP_READ;
        end
    end

endmodule

//--- logic/llc_pkg.sv
package llc_pkg;

    localparam int LLC_WAYS = 4;
    localparam int LLC_SETS = 4;
    localparam int SET_BITS = 2;
    localparam int WAY_BITS = 2;
    localparam int TAG_BITS = 6;
    localparam int LINE_BITS = 32;

    typedef logic [SET_BITS-1:0] llc_set_t;
    typedef logic [WAY_BITS-1:0] llc_way_t;
    typedef logic [TAG_BITS-1:0] llc_tag_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [TAG_BITS+SET_BITS-1:0] line_addr_t; // tag sits above the set.

    typedef enum logic {INVALID, VALID} llc_state_t;

    typedef enum logic {RSP_DATA, RSP_INVACK} coh_msg_t;

    typedef enum logic [1:0] {OP_NONE, OP_RSP, OP_FLUSH, OP_READ} proc_op_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_SET,
        PROCESS_NEXT,
        FLUSH_WALK,
        EVICT,
        FINISH_FLUSH
    } proc_state_t;

endpackage

//--- logic/llc_process_request.sv
`timescale 1ns/1ps

module llc_process_request (
    input  logic                 clk,
    input  logic                 rst,
    input  llc_pkg::proc_op_t    op,
    input  llc_pkg::line_addr_t  op_addr,
    input  llc_pkg::coh_msg_t    op_msg,
    input  llc_pkg::line_t       op_line,
    input  logic                 recall_pending,
    input  llc_pkg::line_addr_t  recall_addr,
    output logic                 op_taken,
    output logic                 clr_recall,
    output logic                 load_set,
    output llc_pkg::llc_set_t    set,
    output llc_pkg::llc_tag_t    tag,
    output logic                 wr_en,
    output llc_pkg::llc_way_t    wr_way,
    output llc_pkg::llc_state_t  wr_state,
    output llc_pkg::llc_tag_t    wr_tag,
    output logic                 wr_dirty,
    output llc_pkg::line_t       wr_line,
    output logic                 wb_strobe,
    output logic                 wb_fill,
    input  logic                 buf_hit,
    input  llc_pkg::llc_way_t    buf_hit_way,
    input  llc_pkg::llc_way_t    buf_fill_way,
    input  logic                 buf_fill_victim,
    input  llc_pkg::llc_state_t  buf_state [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_tag_t    buf_tag   [llc_pkg::LLC_WAYS],
    input  logic                 buf_dirty [llc_pkg::LLC_WAYS],
    input  llc_pkg::line_t       buf_line  [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_set_t    buf_set,
    input  logic                 mem_req_ready,
    output logic                 mem_req_valid,
    output llc_pkg::line_addr_t  mem_req_addr,
    output llc_pkg::line_t       mem_req_line,
    output logic                 rd_done,
    output logic                 rd_hit,
    output llc_pkg::line_t       rd_line,
    output logic                 flush_done
);

    llc_pkg::proc_state_t state, next_state;
    llc_pkg::proc_op_t    cur_op;
    llc_pkg::line_addr_t  cur_addr;
    llc_pkg::coh_msg_t    cur_msg;
    llc_pkg::line_t       cur_line;
    llc_pkg::llc_way_t    way, mem_way;
    logic                 start, is_recall, evict_needed, walk_dirty, walk_step;

    // the next op waits one cycle while a write-back is in flight.
    assign start = state == llc_pkg::IDLE && op != llc_pkg::OP_NONE && !wb_strobe;
    assign op_taken = start;
    assign load_set = start;
    assign set = op_addr[llc_pkg::SET_BITS-1:0];
    assign tag = cur_addr[llc_pkg::TAG_BITS+llc_pkg::SET_BITS-1:llc_pkg::SET_BITS];

    assign is_recall = recall_pending && cur_addr == recall_addr;
    assign evict_needed = cur_op == llc_pkg::OP_RSP && !is_recall && !buf_hit &&
                          buf_state[buf_fill_way] == llc_pkg::VALID && buf_dirty[buf_fill_way];
    assign walk_dirty = buf_state[way] == llc_pkg::VALID && buf_dirty[way];
    assign walk_step = state == llc_pkg::FLUSH_WALK && (!walk_dirty || mem_req_ready);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= llc_pkg::IDLE;
            cur_op <= llc_pkg::OP_NONE;
            way <= '0;
            wb_strobe <= 1'b0;
            wb_fill <= 1'b0;
        end else begin
            state <= next_state;
            if (start) cur_op <= op;
            if (start) way <= '0;
            else if (walk_step) way <= way + llc_pkg::llc_way_t'(1);
            wb_strobe <= (state == llc_pkg::PROCESS_NEXT && cur_op == llc_pkg::OP_RSP) ||
                         (walk_step && next_state == llc_pkg::FINISH_FLUSH);
            wb_fill <= state == llc_pkg::PROCESS_NEXT && cur_op == llc_pkg::OP_RSP &&
                       !is_recall && !buf_hit && buf_fill_victim;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_addr <= op_addr;
            cur_msg <= op_msg;
            cur_line <= op_line;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            llc_pkg::IDLE:         if (start) next_state = llc_pkg::LOAD_SET;
            llc_pkg::LOAD_SET: begin
                if (cur_op == llc_pkg::OP_FLUSH) next_state = llc_pkg::FLUSH_WALK;
                else if (evict_needed) next_state = llc_pkg::EVICT;
                else next_state = llc_pkg::PROCESS_NEXT;
            end
            llc_pkg::PROCESS_NEXT: next_state = llc_pkg::IDLE;
            llc_pkg::FLUSH_WALK: begin
                if (walk_step && way == llc_pkg::llc_way_t'(llc_pkg::LLC_WAYS - 1))
                    next_state = llc_pkg::FINISH_FLUSH;
            end
            llc_pkg::EVICT:        if (mem_req_ready) next_state = llc_pkg::PROCESS_NEXT;
            default:               next_state = llc_pkg::IDLE;
        endcase
    end

    assign mem_way = state == llc_pkg::EVICT ? buf_fill_way : way;
    assign mem_req_addr = {buf_tag[mem_way], buf_set};
    assign mem_req_line = buf_line[mem_way];
    assign flush_done = state == llc_pkg::FINISH_FLUSH;

    always_comb begin
        mem_req_valid = 1'b0;
        wr_en = 1'b0;
        wr_way = buf_hit ? buf_hit_way : buf_fill_way;
        wr_state = llc_pkg::VALID;
        wr_tag = tag;
        wr_dirty = 1'b1;    // lines from a private cache are newer than memory.
        wr_line = cur_line;
        clr_recall = 1'b0;
        rd_done = 1'b0;
        rd_hit = 1'b0;
        rd_line = '0;
        case (state)
            llc_pkg::EVICT: mem_req_valid = 1'b1;
            llc_pkg::FLUSH_WALK: begin
                mem_req_valid = walk_dirty;
                wr_en = walk_dirty && mem_req_ready; // written back, so clean now.
                wr_way = way;
                wr_tag = buf_tag[way];
                wr_dirty = 1'b0;
                wr_line = buf_line[way];
            end
            llc_pkg::PROCESS_NEXT: begin
                if (cur_op == llc_pkg::OP_READ) begin
                    rd_done = 1'b1;
                    rd_hit = buf_hit;
                    rd_line = buf_hit ? buf_line[buf_hit_way] : '0;
                end else if (is_recall) begin
                    clr_recall = 1'b1;
                    wr_en = cur_msg == llc_pkg::RSP_DATA && buf_hit;
                end else begin
                    wr_en = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- logic/llc_set_buffer.sv
`timescale 1ns/1ps

module llc_set_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_set,
    input  llc_pkg::llc_set_t   set,
    input  llc_pkg::llc_tag_t   tag,
    input  llc_pkg::llc_state_t rd_state [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_tag_t   rd_tag   [llc_pkg::LLC_WAYS],
    input  logic                rd_dirty [llc_pkg::LLC_WAYS],
    input  llc_pkg::line_t      rd_line  [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_way_t   rd_victim,
    input  logic                wr_en,
    input  llc_pkg::llc_way_t   wr_way,
    input  llc_pkg::llc_state_t wr_state,
    input  llc_pkg::llc_tag_t   wr_tag,
    input  logic                wr_dirty,
    input  llc_pkg::line_t      wr_line,
    output logic                buf_hit,
    output llc_pkg::llc_way_t   buf_hit_way,
    output llc_pkg::llc_way_t   buf_fill_way,
    output logic                buf_fill_victim,
    output llc_pkg::llc_state_t buf_state [llc_pkg::LLC_WAYS],
    output llc_pkg::llc_tag_t   buf_tag   [llc_pkg::LLC_WAYS],
    output logic                buf_dirty [llc_pkg::LLC_WAYS],
    output llc_pkg::line_t      buf_line  [llc_pkg::LLC_WAYS],
    output llc_pkg::llc_set_t   buf_set
);

    llc_pkg::llc_way_t victim_q; // victim pointer of the buffered set.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            buf_set <= '0;
            victim_q <= '0;
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++)
                buf_state[w] <= llc_pkg::INVALID;
        end else if (load_set) begin
            buf_set <= set;
            victim_q <= rd_victim;
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++)
                buf_state[w] <= rd_state[w];
        end else if (wr_en) begin
            buf_state[wr_way] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (load_set) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                buf_tag[w] <= rd_tag[w];
                buf_dirty[w] <= rd_dirty[w];
                buf_line[w] <= rd_line[w];
            end
        end else if (wr_en) begin
            buf_tag[wr_way] <= wr_tag;
            buf_dirty[wr_way] <= wr_dirty;
            buf_line[wr_way] <= wr_line;
        end
    end

    // scanning downwards leaves the lowest matching way in place.
    always_comb begin
        buf_hit = 1'b0;
        buf_hit_way = '0;
        buf_fill_victim = 1'b1;
        buf_fill_way = victim_q;
        for (int w = llc_pkg::LLC_WAYS - 1; w >= 0; w--) begin
            if (buf_state[w] == llc_pkg::VALID && buf_tag[w] == tag) begin
                buf_hit = 1'b1;
                buf_hit_way = llc_pkg::llc_way_t'(w);
            end
            if (buf_state[w] == llc_pkg::INVALID) begin
                buf_fill_victim = 1'b0;
                buf_fill_way = llc_pkg::llc_way_t'(w);
            end
        end
    end

endmodule

//--- logic/llc_slice.sv
`timescale 1ns/1ps

module llc_slice (
    input  logic                clk,
    input  logic                rst,
    input  logic                rsp_valid,
    input  llc_pkg::coh_msg_t   rsp_msg,
    input  llc_pkg::line_addr_t rsp_addr,
    input  llc_pkg::line_t      rsp_line,
    input  logic                rd_valid,
    input  llc_pkg::line_addr_t rd_addr,
    input  logic                flush_valid,
    input  llc_pkg::llc_set_t   flush_set,
    input  logic                recall_valid,
    input  llc_pkg::line_addr_t recall_addr,
    input  logic                mem_req_ready,
    output logic                mem_req_valid,
    output llc_pkg::line_addr_t mem_req_addr,
    output llc_pkg::line_t      mem_req_line,
    output logic                rd_done,
    output logic                rd_hit,
    output llc_pkg::line_t      rd_line,
    output logic                flush_done
);

    llc_pkg::proc_op_t   op;
    llc_pkg::line_addr_t op_addr, armed_addr;
    llc_pkg::coh_msg_t   op_msg;
    llc_pkg::line_t      op_line, wr_line;
    logic                op_taken, recall_pending, clr_recall, load_set;
    llc_pkg::llc_set_t   set, buf_set;
    llc_pkg::llc_tag_t   tag, wr_tag;
    logic                wr_en, wr_dirty, wb_strobe, wb_fill;
    llc_pkg::llc_way_t   wr_way, rd_victim, buf_hit_way, buf_fill_way;
    llc_pkg::llc_state_t wr_state;
    logic                buf_hit, buf_fill_victim;

    llc_pkg::llc_state_t rd_state  [llc_pkg::LLC_WAYS];
    llc_pkg::llc_tag_t   rd_tag    [llc_pkg::LLC_WAYS];
    logic                rd_dirty  [llc_pkg::LLC_WAYS];
    llc_pkg::line_t      st_line   [llc_pkg::LLC_WAYS];
    llc_pkg::llc_state_t buf_state [llc_pkg::LLC_WAYS];
    llc_pkg::llc_tag_t   buf_tag   [llc_pkg::LLC_WAYS];
    logic                buf_dirty [llc_pkg::LLC_WAYS];
    llc_pkg::line_t      buf_line  [llc_pkg::LLC_WAYS];

    llc_input_select input_select0 (
        .clk, .rst, .rsp_valid, .rsp_msg, .rsp_addr, .rsp_line, .rd_valid, .rd_addr,
        .flush_valid, .flush_set, .recall_valid, .recall_arm_addr(recall_addr),
        .op_taken, .clr_recall, .op, .op_addr, .op_msg, .op_line, .recall_pending,
        .recall_addr(armed_addr)
    );

    llc_tag_store tag_store0 (
        .clk, .rst, .rd_set(set), .rd_state, .rd_tag, .rd_dirty, .rd_line(st_line),
        .rd_victim, .wb_strobe, .wb_fill, .wb_set(buf_set), .wb_state(buf_state),
        .wb_tag(buf_tag), .wb_dirty(buf_dirty), .wb_line(buf_line)
    );

    llc_set_buffer set_buffer0 (
        .clk, .rst, .load_set, .set, .tag, .rd_state, .rd_tag, .rd_dirty,
        .rd_line(st_line), .rd_victim, .wr_en, .wr_way, .wr_state, .wr_tag, .wr_dirty,
        .wr_line, .buf_hit, .buf_hit_way, .buf_fill_way, .buf_fill_victim, .buf_state,
        .buf_tag, .buf_dirty, .buf_line, .buf_set
    );

    llc_process_request process_request0 (
        .clk, .rst, .op, .op_addr, .op_msg, .op_line, .recall_pending,
        .recall_addr(armed_addr), .op_taken, .clr_recall, .load_set, .set, .tag,
        .wr_en, .wr_way, .wr_state, .wr_tag, .wr_dirty, .wr_line, .wb_strobe, .wb_fill,
        .buf_hit, .buf_hit_way, .buf_fill_way, .buf_fill_victim, .buf_state, .buf_tag,
        .buf_dirty, .buf_line, .buf_set, .mem_req_ready, .mem_req_valid, .mem_req_addr,
        .mem_req_line, .rd_done, .rd_hit, .rd_line, .flush_done
    );

endmodule

//--- logic/llc_tag_store.sv
`timescale 1ns/1ps

module llc_tag_store (
    input  logic                clk,
    input  logic                rst,
    input  llc_pkg::llc_set_t   rd_set,
    output llc_pkg::llc_state_t rd_state [llc_pkg::LLC_WAYS],
    output llc_pkg::llc_tag_t   rd_tag   [llc_pkg::LLC_WAYS],
    output logic                rd_dirty [llc_pkg::LLC_WAYS],
    output llc_pkg::line_t      rd_line  [llc_pkg::LLC_WAYS],
    output llc_pkg::llc_way_t   rd_victim,
    input  logic                wb_strobe,
    input  logic                wb_fill,
    input  llc_pkg::llc_set_t   wb_set,
    input  llc_pkg::llc_state_t wb_state [llc_pkg::LLC_WAYS],
    input  llc_pkg::llc_tag_t   wb_tag   [llc_pkg::LLC_WAYS],
    input  logic                wb_dirty [llc_pkg::LLC_WAYS],
    input  llc_pkg::line_t      wb_line  [llc_pkg::LLC_WAYS]
);

    llc_pkg::llc_state_t states [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    logic                dirty  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_tag_t   tags   [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::line_t      lines  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_way_t   victim [llc_pkg::LLC_SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
                victim[s] <= '0;
                for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                    states[s][w] <= llc_pkg::INVALID;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else if (wb_strobe) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                states[wb_set][w] <= wb_state[w];
                dirty[wb_set][w] <= wb_dirty[w];
            end
            // round robin only moves when every way was already valid.
            if (wb_fill)
                victim[wb_set] <= victim[wb_set] + llc_pkg::llc_way_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_strobe) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                tags[wb_set][w] <= wb_tag[w];
                lines[wb_set][w] <= wb_line[w];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            rd_state[w] = states[rd_set][w];
            rd_tag[w] = tags[rd_set][w];
            rd_dirty[w] = dirty[rd_set][w];
            rd_line[w] = lines[rd_set][w];
        end
    end

    assign rd_victim = victim[rd_set];

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the llc_slice testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module llc_slice_tb \
    -f llc_slice.f -Mdir obj_dir -o llc_slice_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/llc_slice_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- tb/llc_slice_checker.sv
`timescale 1ns/1ps

module llc_slice_checker (
    input logic                clk,
    input logic                rst,
    input logic                mem_req_valid,
    input logic                mem_req_ready,
    input llc_pkg::line_addr_t mem_req_addr,
    input llc_pkg::line_t      mem_req_line,
    input logic                rd_done,
    input logic                flush_done
);

    // a stalled write request keeps its address and line until memory takes it.
    req_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_line))
        else $error("memory write request changed before it was accepted");

    done_exclusive: assert property (@(posedge clk) !(rd_done && flush_done))
        else $error("rd_done and flush_done pulsed in the same cycle");

    quiet_in_reset: assert property (@(posedge clk)
        !rst |-> !(mem_req_valid || rd_done || flush_done))
        else $error("output strobe high while reset is asserted");

endmodule

bind llc_slice llc_slice_checker checker0 (
    .clk, .rst, .mem_req_valid, .mem_req_ready, .mem_req_addr, .mem_req_line,
    .rd_done, .flush_done
);

//--- tb/llc_slice_tb.sv
`timescale 1ns/1ps

module llc_slice_tb;

    typedef enum {T_READ, T_RSP, T_FLUSH, T_RECALL, T_ALL} test_op_t;

    typedef struct {
        test_op_t            op;
        llc_pkg::line_addr_t addr;
        llc_pkg::coh_msg_t   msg;
        llc_pkg::line_t      line;
        bit                  stall;  // random ready stalls on memory writes.
    } entry_t;

    localparam int NUM_ENTRIES = 26;
    localparam int READ_LATENCY = 3; // IDLE, LOAD_SET and PROCESS_NEXT.

    logic                clk, rst;
    logic                rsp_valid, rd_valid, flush_valid, recall_valid, mem_req_ready;
    llc_pkg::coh_msg_t   rsp_msg;
    llc_pkg::line_addr_t rsp_addr, rd_addr, recall_addr, mem_req_addr;
    llc_pkg::llc_set_t   flush_set;
    llc_pkg::line_t      rsp_line, mem_req_line, rd_line;
    logic                mem_req_valid, rd_done, rd_hit, flush_done;
    int                  seed = 32'hc24b;
    bit                  stall;

    // reference copy of the cache contents.
    bit                  m_valid  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_tag_t   m_tag    [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    bit                  m_dirty  [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::line_t      m_line   [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    int                  m_victim [llc_pkg::LLC_SETS];
    bit                  rc_pend;
    llc_pkg::line_addr_t rc_addr;
    llc_pkg::line_addr_t exp_addr[$], got_addr[$];
    llc_pkg::line_t      exp_line[$], got_line[$];

    entry_t tests [NUM_ENTRIES] = '{
        '{T_READ,   8'h05, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_READ,   8'hfe, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h05, llc_pkg::RSP_DATA,   32'h1111_0005, 1'b0},
        '{T_READ,   8'h05, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h09, llc_pkg::RSP_DATA,   32'h2222_0009, 1'b0},
        '{T_RSP,    8'h0d, llc_pkg::RSP_DATA,   32'h3333_000d, 1'b0},
        '{T_RSP,    8'h11, llc_pkg::RSP_DATA,   32'h4444_0011, 1'b0},
        '{T_RSP,    8'h15, llc_pkg::RSP_DATA,   32'h5555_0015, 1'b0},
        '{T_READ,   8'h15, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_READ,   8'h05, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h19, llc_pkg::RSP_DATA,   32'h6666_0019, 1'b1},
        '{T_READ,   8'h19, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h15, llc_pkg::RSP_DATA,   32'h5a5a_0015, 1'b0},
        '{T_FLUSH,  8'h01, llc_pkg::RSP_DATA,   32'h0,         1'b1},
        '{T_FLUSH,  8'h01, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h1d, llc_pkg::RSP_DATA,   32'h7777_001d, 1'b0},
        '{T_READ,   8'h0d, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h22, llc_pkg::RSP_DATA,   32'hc0de_0022, 1'b0},
        '{T_FLUSH,  8'h02, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RECALL, 8'h22, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h22, llc_pkg::RSP_INVACK, 32'hdead_0022, 1'b0},
        '{T_READ,   8'h22, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RECALL, 8'h22, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_RSP,    8'h22, llc_pkg::RSP_DATA,   32'hbeef_0022, 1'b0},
        '{T_FLUSH,  8'h02, llc_pkg::RSP_DATA,   32'h0,         1'b0},
        '{T_ALL,    8'h27, llc_pkg::RSP_DATA,   32'hf00d_0027, 1'b1}
    };

    llc_slice dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_with(input string reason);
        $display("%s", reason);
        stop_run();
    endtask

    task automatic check_line(input string name, input llc_pkg::line_t got,
                              input llc_pkg::line_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input llc_pkg::line_addr_t got,
                              input llc_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic int set_of(input llc_pkg::line_addr_t a);
        return int'(a[llc_pkg::SET_BITS-1:0]);
    endfunction

    function automatic int find_hit(input llc_pkg::line_addr_t a);
        int s;
        s = set_of(a);
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a[llc_pkg::SET_BITS+:llc_pkg::TAG_BITS])
                return w;
        end
        return -1;
    endfunction

    task automatic push_writeback(input int s, input int w);
        exp_addr.push_back({m_tag[s][w], llc_pkg::llc_set_t'(s)});
        exp_line.push_back(m_line[s][w]);
    endtask

    task automatic model_rsp(input llc_pkg::line_addr_t a, input llc_pkg::coh_msg_t msg,
                             input llc_pkg::line_t l);
        int s;
        int w;
        bit write;
        s = set_of(a);
        w = find_hit(a);
        write = 1'b1;
        if (rc_pend && a == rc_addr) begin
            rc_pend = 1'b0; // recall data lands only on a line that is present.
            write = msg == llc_pkg::RSP_DATA && w >= 0;
        end else if (w < 0) begin
            for (int i = llc_pkg::LLC_WAYS - 1; i >= 0; i--) begin
                if (!m_valid[s][i])
                    w = i;
            end
            if (w < 0) begin
                w = m_victim[s];
                m_victim[s] = (m_victim[s] + 1) % llc_pkg::LLC_WAYS;
            end
            if (m_valid[s][w] && m_dirty[s][w])
                push_writeback(s, w);
        end
        if (write) begin
            m_valid[s][w] = 1'b1;
            m_tag[s][w] = a[llc_pkg::SET_BITS+:llc_pkg::TAG_BITS];
            m_dirty[s][w] = 1'b1;
            m_line[s][w] = l;
        end
    endtask

    task automatic model_flush(input int s);
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (m_valid[s][w] && m_dirty[s][w]) begin
                push_writeback(s, w);
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic compare_writes();
        if (got_addr.size() != exp_addr.size())
            fail_with($sformatf("saw %0d memory writes where %0d were expected",
                                got_addr.size(), exp_addr.size()));
        while (exp_addr.size() != 0) begin
            check_addr("mem_req_addr", got_addr.pop_front(), exp_addr.pop_front());
            check_line("mem_req_line", got_line.pop_front(), exp_line.pop_front());
        end
    endtask

    task automatic wait_read(input llc_pkg::line_addr_t a, input bit timed);
        int cycles;
        int w;
        llc_pkg::line_t exp;
        cycles = 1;
        while (!rd_done) begin
            @(negedge clk);
            cycles++;
        end
        w = find_hit(a);
        exp = '0;
        if (w >= 0)
            exp = m_line[set_of(a)][w];
        check_hit("rd_hit", rd_hit, w >= 0);
        check_line("rd_line", rd_line, exp);
        if (timed && cycles != READ_LATENCY)
            fail_with($sformatf("read finished after %0d cycles instead of %0d",
                                cycles, READ_LATENCY));
    endtask

    task automatic wait_flush();
        while (!flush_done) begin
            if (rd_done)
                fail_with("a read finished before the flush that came with it");
            @(negedge clk);
        end
        compare_writes();
    endtask

    task automatic run_entry(input entry_t e);
        stall = e.stall;
        if (e.op == T_RSP || e.op == T_ALL) begin
            rsp_valid = 1'b1;
            rsp_addr = e.addr;
            rsp_msg = e.msg;
            rsp_line = e.line;
            model_rsp(e.addr, e.msg, e.line);
        end
        if (e.op == T_FLUSH || e.op == T_ALL) begin
            flush_valid = 1'b1;
            flush_set = e.addr[llc_pkg::SET_BITS-1:0];
            model_flush(set_of(e.addr));
        end
        if (e.op == T_READ || e.op == T_ALL) begin
            rd_valid = 1'b1;
            rd_addr = e.addr;
        end
        if (e.op == T_RECALL) begin
            recall_valid = 1'b1;
            recall_addr = e.addr;
            rc_pend = 1'b1;
            rc_addr = e.addr;
        end
        @(negedge clk);
        rsp_valid = 1'b0;
        rd_valid = 1'b0;
        flush_valid = 1'b0;
        recall_valid = 1'b0;
        case (e.op)
            T_READ: wait_read(e.addr, 1'b1);
            T_RSP: begin
                while (got_addr.size() < exp_addr.size())
                    @(negedge clk);
                repeat (4) @(negedge clk); // the fill lands 3 cycles after acceptance.
                compare_writes();
            end
            T_FLUSH: wait_flush();
            T_ALL: begin
                wait_flush();
                wait_read(e.addr, 1'b0);
            end
            default: ;
        endcase
    endtask

    // memory side, ready for the next edge and a record of each transfer.
    initial begin
        mem_req_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall)
                mem_req_ready = $random(seed) % 2 != 0;
            else
                mem_req_ready = 1'b1;
            if (rst && mem_req_valid && mem_req_ready) begin
                got_addr.push_back(mem_req_addr);
                got_line.push_back(mem_req_line);
            end
        end
    end

    initial begin
        repeat (16 + NUM_ENTRIES * 200) @(posedge clk);
        fail_with("watchdog expired before the stimulus table finished");
    end

    initial begin
        rst = 1'b0;
        stall = 1'b0;
        rsp_valid = 1'b0;
        rsp_msg = llc_pkg::RSP_DATA;
        rsp_addr = '0;
        rsp_line = '0;
        rd_valid = 1'b0;
        rd_addr = '0;
        flush_valid = 1'b0;
        flush_set = '0;
        recall_valid = 1'b0;
        recall_addr = '0;
        rc_pend = 1'b0;
        rc_addr = '0;
        for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
            m_victim[s] = 0;
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        repeat (16) @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(negedge clk);
            run_entry(tests[i]);
        end
        repeat (10) @(negedge clk);
        if (got_addr.size() != 0) begin
            fail_with("memory write seen after the last operation finished");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
